// File: cachePkg.sv
package cachePkg;

  // byte address and data word
  localparam int addrWidth = 32;
  localparam int xlen = 64;

  // address split as tag | index | offset
  localparam int tagWidth = 21;
  localparam int indexWidth = 6;
  localparam int offsetWidth = 5;

  // two ways of 64 sets, 256-bit lines
  localparam int numSets = 64;
  localparam int beatsPerLine = 4;

  typedef logic [addrWidth-1:0] addrT;
  typedef logic [xlen-1:0] wordT;
  typedef logic [tagWidth-1:0] tagT;
  typedef logic [indexWidth-1:0] indexT;

  // one SRAM word holds half a line
  typedef logic [2*xlen-1:0] halfLineT;
  typedef logic [beatsPerLine*xlen-1:0] lineT;

  // controller states
  typedef enum logic [1:0] {
    idle,
    compare,
    miss,
    refill
  } ctrlStateT;

endpackage

// File: busPkg.sv
package busPkg;

  // pipeline request, reads only
  typedef struct packed {
    cachePkg::addrT addr;
  } cacheReqT;

  // line assembled from the memory beats
  // done is high for one cycle once all beats are in
  typedef struct packed {
    cachePkg::lineT line;
    logic done;
  } refillLineT;

endpackage

// File: dataSram.sv
module dataSram (
  input  logic               clk,
  input  logic               ce_i,
  input  logic               we_i,
  input  cachePkg::indexT    addr_i,
  input  cachePkg::halfLineT d_i,
  output cachePkg::halfLineT q_o
);
  import cachePkg::*;

  halfLineT mem [numSets];

  // single port, write wins over read
  always_ff @(posedge clk) begin
    if (ce_i) begin
      if (we_i) begin
        mem[addr_i] <= d_i;
      end else begin
        q_o <= mem[addr_i];
      end
    end
  end

endmodule

// File: tagValidArray.sv
module tagValidArray (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            lookup_i,
  input  cachePkg::indexT lookupIdx_i,
  input  logic            wr_i,
  input  cachePkg::indexT wrIdx_i,
  input  cachePkg::tagT   wrTag_i,
  output cachePkg::tagT   tag_o,
  output logic            valid_o
);
  import cachePkg::*;

  tagT tags [numSets];
  logic [numSets-1:0] validVec;

  // valid bits start cleared, set by each refill
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validVec <= '0;
    end else if (wr_i) begin
      validVec[wrIdx_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_i) begin
      tags[wrIdx_i] <= wrTag_i;
    end
  end

  // registered lookup, same edge as the data SRAMs
  always_ff @(posedge clk) begin
    if (lookup_i) begin
      tag_o <= tags[lookupIdx_i];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_o <= 1'b0;
    end else if (lookup_i) begin
      valid_o <= validVec[lookupIdx_i];
    end
  end

endmodule

// File: lineRefill.sv
module lineRefill (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start_i,
  input  cachePkg::addrT     lineAddr_i,
  output logic               cacheRdValid_o,
  output cachePkg::addrT     cacheAddr_o,
  input  logic               rdBeat_i,
  input  logic               rdLast_i,
  input  cachePkg::wordT     rdData_i,
  output busPkg::refillLineT refill_o
);
  import cachePkg::*;

  logic [$clog2(beatsPerLine)-1:0] beatCnt;
  lineT lineBuf;
  logic doneQ;

  // request stays up until the first beat comes back
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cacheRdValid_o <= 1'b0;
      beatCnt <= '0;
      doneQ <= 1'b0;
    end else begin
      doneQ <= rdBeat_i && rdLast_i;
      if (start_i) begin
        cacheRdValid_o <= 1'b1;
        beatCnt <= '0;
      end else if (rdBeat_i) begin
        cacheRdValid_o <= 1'b0;
        beatCnt <= beatCnt + 1'b1;
      end
    end
  end

  // line-aligned address and beat buffer
  always_ff @(posedge clk) begin
    if (start_i) begin
      cacheAddr_o <= {lineAddr_i[addrWidth-1:offsetWidth], {offsetWidth{1'b0}}};
    end
    if (rdBeat_i) begin
      // beat n fills quarter n, lowest address first
      lineBuf[beatCnt*xlen +: xlen] <= rdData_i;
    end
  end

  // line is complete whenever done is high
  assign refill_o.line = lineBuf;
  assign refill_o.done = doneQ;

endmodule

// File: cacheCtrl.sv
module cacheCtrl (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               valid_i,
  input  busPkg::cacheReqT   req_i,
  output logic               addrOk_o,
  output logic               dataOk_o,
  output cachePkg::wordT     rdData_o,
  output logic               lookup_o,
  output cachePkg::indexT    lookupIdx_o,
  input  cachePkg::tagT      tag1_i,
  input  cachePkg::tagT      tag2_i,
  input  logic               valid1_i,
  input  logic               valid2_i,
  input  cachePkg::lineT     line1_i,
  input  cachePkg::lineT     line2_i,
  output logic [1:0]         wayWr_o,
  output cachePkg::tagT      wrTag_o,
  output cachePkg::lineT     wrLine_o,
  output logic               refillStart_o,
  output cachePkg::addrT     refillAddr_o,
  input  busPkg::refillLineT refill_i
);
  import cachePkg::*;
  import busPkg::*;

  ctrlStateT state;
  ctrlStateT nextState;
  cacheReqT reqQ;
  tagT reqTag;
  indexT reqIdx;
  logic [$clog2(beatsPerLine)-1:0] wordSel;
  logic way1Hit;
  logic way2Hit;
  logic hit;
  logic accept;
  logic replayQ;
  logic refillBusy;
  logic victimQ;
  logic [3:0] lfsr;
  lineT hitLine;

  // fields of the request being compared
  assign reqTag = reqQ.addr[addrWidth-1 -: tagWidth];
  assign reqIdx = reqQ.addr[offsetWidth +: indexWidth];
  assign wordSel = reqQ.addr[offsetWidth-1 -: $clog2(beatsPerLine)];

  assign way1Hit = valid1_i && (tag1_i == reqTag);
  assign way2Hit = valid2_i && (tag2_i == reqTag);
  assign hit = way1Hit || way2Hit;

  // idle takes a request unless a replay is due; compare only on a hit
  assign addrOk_o = ((state == idle) && !replayQ) || ((state == compare) && hit);
  assign accept = valid_i && addrOk_o;
  assign dataOk_o = (state == compare) && hit;

  assign hitLine = way1Hit ? line1_i : line2_i;
  assign rdData_o = hitLine[wordSel*xlen +: xlen];

  // lookup for a new request, or the replay after a refill
  assign lookup_o = accept || ((state == idle) && replayQ);
  assign lookupIdx_o = addrOk_o ? req_i.addr[offsetWidth +: indexWidth] : reqIdx;

  // refill side
  assign refillStart_o = (state == miss) && !refillBusy;
  assign refillAddr_o = {reqQ.addr[addrWidth-1:offsetWidth], {offsetWidth{1'b0}}};
  assign wayWr_o = (state == refill) ? (victimQ ? 2'b10 : 2'b01) : 2'b00;
  assign wrTag_o = reqTag;
  assign wrLine_o = refill_i.line;

  always_comb begin
    nextState = state;
    case (state)
      idle: begin
        if (replayQ || valid_i) begin
          nextState = compare;
        end
      end
      compare: begin
        if (!hit) begin
          nextState = miss;
        end else if (!valid_i) begin
          nextState = idle;
        end
      end
      miss: begin
        if (refill_i.done) begin
          nextState = refill;
        end
      end
      refill: begin
        nextState = idle;
      end
      default: begin
        nextState = idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= idle;
      replayQ <= 1'b0;
      refillBusy <= 1'b0;
      victimQ <= 1'b0;
      lfsr <= 4'b1001;
    end else begin
      state <= nextState;
      // refill always returns to idle, so the replay flag lasts one cycle
      replayQ <= (state == refill);
      // x^4 + x^3 + 1, free running
      lfsr <= {lfsr[2:0], lfsr[3] ^ lfsr[2]};
      if (refillStart_o) begin
        refillBusy <= 1'b1;
      end else if (refill_i.done) begin
        refillBusy <= 1'b0;
      end
      // empty way first, otherwise a pseudo-random one
      if ((state == compare) && !hit) begin
        if (!valid1_i) begin
          victimQ <= 1'b0;
        end else if (!valid2_i) begin
          victimQ <= 1'b1;
        end else begin
          victimQ <= lfsr[0];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqQ <= req_i;
    end
  end

endmodule

// File: dcacheTop.sv
module dcacheTop (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             valid_i,
  input  busPkg::cacheReqT req_i,
  output logic             addrOk_o,
  output logic             dataOk_o,
  output cachePkg::wordT   rdData_o,
  output logic             cacheRdValid_o,
  output cachePkg::addrT   cacheAddr_o,
  input  logic             rdBeat_i,
  input  logic             rdLast_i,
  input  cachePkg::wordT   rdData_i
);
  import cachePkg::*;
  import busPkg::*;

  logic lookup;
  indexT lookupIdx;
  tagT wayTag [2];
  logic wayValid [2];
  lineT wayLine [2];
  logic [1:0] wayWr;
  tagT wrTag;
  lineT wrLine;
  logic refillStart;
  addrT refillAddr;
  refillLineT refillLine;

  cacheCtrl cacheCtrl_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .valid_i       (valid_i),
    .req_i         (req_i),
    .addrOk_o      (addrOk_o),
    .dataOk_o      (dataOk_o),
    .rdData_o      (rdData_o),
    .lookup_o      (lookup),
    .lookupIdx_o   (lookupIdx),
    .tag1_i        (wayTag[0]),
    .tag2_i        (wayTag[1]),
    .valid1_i      (wayValid[0]),
    .valid2_i      (wayValid[1]),
    .line1_i       (wayLine[0]),
    .line2_i       (wayLine[1]),
    .wayWr_o       (wayWr),
    .wrTag_o       (wrTag),
    .wrLine_o      (wrLine),
    .refillStart_o (refillStart),
    .refillAddr_o  (refillAddr),
    .refill_i      (refillLine)
  );

  // per way: tag array plus low and high data halves
  for (genvar w = 0; w < 2; w++) begin : gWay
    logic sramCe;
    halfLineT qLo;
    halfLineT qHi;

    assign sramCe = lookup || wayWr[w];
    assign wayLine[w] = {qHi, qLo};

    tagValidArray tagArray_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .lookup_i    (lookup),
      .lookupIdx_i (lookupIdx),
      .wr_i        (wayWr[w]),
      .wrIdx_i     (lookupIdx),
      .wrTag_i     (wrTag),
      .tag_o       (wayTag[w]),
      .valid_o     (wayValid[w])
    );

    dataSram sramLo_i (
      .clk    (clk),
      .ce_i   (sramCe),
      .we_i   (wayWr[w]),
      .addr_i (lookupIdx),
      .d_i    (wrLine[$bits(halfLineT)-1:0]),
      .q_o    (qLo)
    );

    dataSram sramHi_i (
      .clk    (clk),
      .ce_i   (sramCe),
      .we_i   (wayWr[w]),
      .addr_i (lookupIdx),
      .d_i    (wrLine[$bits(lineT)-1 -: $bits(halfLineT)]),
      .q_o    (qHi)
    );
  end

  lineRefill lineRefill_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .start_i        (refillStart),
    .lineAddr_i     (refillAddr),
    .cacheRdValid_o (cacheRdValid_o),
    .cacheAddr_o    (cacheAddr_o),
    .rdBeat_i       (rdBeat_i),
    .rdLast_i       (rdLast_i),
    .rdData_i       (rdData_i),
    .refill_o       (refillLine)
  );

endmodule

// File: dcacheTop_props.sv
module dcacheTop_props (
  input logic                clk,
  input logic                rst_n,
  input cachePkg::ctrlStateT state_i,
  input logic                dataOk_i,
  input logic                refillStart_i,
  input logic                lookup_i
);
  import cachePkg::*;

  // data comes from arrays read on the edge before
  dataOkNotIdle: assert property (@(posedge clk) disable iff (!rst_n)
    dataOk_i |-> state_i != idle && $past(lookup_i))
    else $error("dataOk_o raised in idle or without a lookup the cycle before");

  // one read request per miss, on the cycle miss is entered
  refillStartInMiss: assert property (@(posedge clk) disable iff (!rst_n)
    refillStart_i |-> state_i == miss && $past(state_i) == compare)
    else $error("refill started outside the first miss cycle");

  // arrays are written here, the replay lookup follows
  noLookupInRefill: assert property (@(posedge clk) disable iff (!rst_n)
    state_i == refill |-> !lookup_i ##1 lookup_i)
    else $error("lookup issued during refill or replay lookup missing");

endmodule

bind cacheCtrl dcacheTop_props props_i (
  .clk           (clk),
  .rst_n         (rst_n),
  .state_i       (state),
  .dataOk_i      (dataOk_o),
  .refillStart_i (refillStart_o),
  .lookup_i      (lookup_o)
);

// File: dcache_tb.sv
module dcache_tb;
  import cachePkg::*;
  import busPkg::*;

  localparam int numReq = 500;
  localparam int waitLimit = 300;

  logic clk;
  logic rst_n;
  logic valid_i;
  cacheReqT req_i;
  logic addrOk_o;
  logic dataOk_o;
  wordT rdData_o;
  logic cacheRdValid_o;
  addrT cacheAddr_o;
  logic rdBeat_i;
  logic rdLast_i;
  wordT rdData_i;

  // reference model: newest refilled tag per set, plus the other way
  tagT newTag [numSets];
  tagT oldTag [numSets];
  logic oldKnown [numSets];
  int fills [numSets];
  addrT pending [$];
  time acceptTime [$];
  addrT refillLine;
  logic refillSeen = 1'b0;
  int unsigned lcgState = 89;
  int errors = 0;
  int checks = 0;

  dcacheTop dcacheTop_i (.*);

  function automatic int unsigned nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState >> 16;
  endfunction

  // memory contents, a fixed hash of the word address
  function automatic wordT memWord(addrT a);
    return {a * 32'h9e3779b1, a ^ 32'hc3a55a3c};
  endfunction

  task automatic checkEqual(string what, wordT got, wordT exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic endRun(string why);
    if (why != "") begin
      errors++;
      $display("%s at %0t", why, $time);
    end
    $display("errors %0d over %0d checks", errors, checks);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  // each dataOk_o retires the oldest accepted request
  initial begin
    addrT a;
    time acc;
    indexT s;
    tagT t;
    logic isNew;
    logic isOld;
    logic possible;
    forever begin
      @(negedge clk);
      if (dataOk_o && pending.size() == 0) begin
        endRun("dataOk_o came with no request outstanding");
      end else if (dataOk_o) begin
        a = pending.pop_front();
        acc = acceptTime.pop_front();
        s = a[offsetWidth +: indexWidth];
        t = a[addrWidth-1 -: tagWidth];
        isNew = fills[s] > 0 && newTag[s] == t;
        isOld = fills[s] == 2 && oldTag[s] == t;
        possible = isNew || isOld || (fills[s] == 2 && !oldKnown[s]);
        checkEqual("read data", rdData_o, memWord({a[addrWidth-1:3], 3'b000}));
        if (refillSeen) begin
          checkEqual("refill of resident line", isNew || (isOld && oldKnown[s]), 0);
          checkEqual("refill address", refillLine, {a[addrWidth-1:offsetWidth], 5'b0});
          // victim is random once both ways are full
          oldKnown[s] = fills[s] == 1;
          oldTag[s] = newTag[s];
          newTag[s] = t;
          fills[s] = (fills[s] < 2) ? fills[s] + 1 : 2;
        end else begin
          checkEqual("hit latency", $time - acc, 8);
          checkEqual("hit on absent line", possible, 1);
          // a hit pins down the second resident line
          if (!isNew) begin
            oldTag[s] = t;
            oldKnown[s] = 1'b1;
          end
        end
        refillSeen = 1'b0;
      end
    end
  end

  // memory responder, four beats with random gaps
  initial begin
    addrT lineAddr;
    forever begin
      @(negedge clk);
      if (cacheRdValid_o) begin
        lineAddr = cacheAddr_o;
        refillLine = cacheAddr_o;
        refillSeen = 1'b1;
        for (int b = 0; b < beatsPerLine; b++) begin
          repeat (nextRand() % 4) @(negedge clk);
          rdBeat_i = 1'b1;
          rdLast_i = (b == beatsPerLine - 1);
          rdData_i = memWord(lineAddr + addrT'(8 * b));
          @(negedge clk);
          rdBeat_i = 1'b0;
          rdLast_i = 1'b0;
        end
      end
    end
  end

  initial begin
    addrT a;
    int waited;
    rst_n = 1'b0;
    valid_i = 1'b0;
    req_i = '0;
    rdBeat_i = 1'b0;
    rdLast_i = 1'b0;
    rdData_i = '0;
    a = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < numReq; i++) begin
      // half the requests stay in the last line, so hits run back to back
      if (nextRand() % 2 == 0) begin
        a[addrWidth-1 -: tagWidth] = tagT'(nextRand() % 5);
        a[offsetWidth +: indexWidth] = indexT'(nextRand() % 4 * 21);
      end
      a[4:3] = 2'(nextRand() % 4);
      if (nextRand() % 8 == 0) begin
        @(negedge clk);
      end
      valid_i = 1'b1;
      req_i.addr = a;
      waited = 0;
      while (!addrOk_o) begin
        @(negedge clk);
        waited++;
        if (waited > waitLimit) begin
          endRun("timeout waiting for addrOk_o");
        end
      end
      pending.push_back(a);
      acceptTime.push_back($time);
      @(negedge clk);
      valid_i = 1'b0;
    end
    waited = 0;
    while (pending.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > waitLimit) begin
        endRun("timeout waiting for the last dataOk_o");
      end
    end
    endRun("");
  end

endmodule

// File: dcache.f
cachePkg.sv
busPkg.sv
dataSram.sv
tagValidArray.sv
lineRefill.sv
cacheCtrl.sv
dcacheTop.sv
dcacheTop_props.sv
dcache_tb.sv
